//--- logic/pe_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared sizes and word layouts for the PE control unit
// burst offsets assume DATA_W is a multiple of BYTE_LEN
// ~~~~~~~~~~~~~~~~~~~~
package pe_ctrl_pkg;

  // array shape
  localparam int PE_ROWS = 5;
  localparam int PE_COLS = 5;

  // AXI master side
  localparam int DATA_W = 32;
  localparam int BYTE_LEN = 8;
  localparam int BURST_LEN = 16;
  localparam int BURST_BYTES = BURST_LEN * DATA_W / BYTE_LEN;
  localparam logic [DATA_W-1:0] TARGET_BASE_ADDR = 32'h4000_0000;

  // bursts per buffer kind
  localparam int WEIGHT_BURSTS = 1;
  localparam int INPUT_BURSTS = 2;
  localparam int PSUM_BURSTS = 3;
  localparam int BURST_CNT_W = $clog2(PSUM_BURSTS + 1);

  // mux select widths
  localparam int ROW_MUX_W = 4;
  localparam int PSUM_MUX_W = 3;

  // accelerator parameter word
  typedef struct packed {
    logic        valid;
    logic        start;
    logic        soft_reset;
    logic        spare;
    logic [11:0] chan_c;
    logic [3:0]  tile_size;
    logic [3:0]  stride_u;
    logic [3:0]  filt_s;
    logic [3:0]  filt_r;
  } acc_params_t;

  // memory control word, only the buffer bits act
  typedef struct packed {
    logic [23:0] spare;
    logic        rsvd_7;
    logic        buffer_psums;
    logic [1:0]  rsvd_5_4;
    logic        buffer_inputs;
    logic [1:0]  rsvd_2_1;
    logic        buffer_weights;
  } mem_ctrl_t;

  // one bit per buffer kind
  typedef struct packed {
    logic weights;
    logic inputs;
    logic psums;
  } buf_req_t;

  typedef struct packed {
    logic [12:0] spare_hi;
    logic        psum_err;
    logic        input_err;
    logic        weight_err;
    logic [12:0] spare_lo;
    logic        psums_buffered;
    logic        inputs_buffered;
    logic        weights_buffered;
  } pe_status_t;

endpackage

//--- logic/ctrl_edge_detect.sv
// ~~~~~~~~~~~~~~~~~~~~
// pulses are registered, one cycle wide
// a level held high through reset pulses once after it
// ~~~~~~~~~~~~~~~~~~~~
module ctrl_edge_detect import pe_ctrl_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  acc_params_t acc_params,
  input  mem_ctrl_t   mem_ctrl,
  output logic        start_pulse,
  output buf_req_t    buf_req
);

  logic [3:0] level;
  logic [3:0] level_q;
  logic [3:0] rise_q;

  // start on top, then the buf_req_t order
  assign level = {acc_params.start, mem_ctrl.buffer_weights,
                  mem_ctrl.buffer_inputs, mem_ctrl.buffer_psums};

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      level_q <= '0;
      rise_q <= '0;
    end else begin
      level_q <= level;
      rise_q <= level & ~level_q;
    end
  end

  assign start_pulse = rise_q[3];
  assign buf_req = rise_q[2:0];

endmodule

//--- logic/array_config.sv
// ~~~~~~~~~~~~~~~~~~~~
// filt_r and filt_s are expected in 1..5 while valid is high
// mac_enable only drops on reset
// ~~~~~~~~~~~~~~~~~~~~
module array_config import pe_ctrl_pkg::*; (
  input  logic                                   CLK,
  input  logic                                   rst_n,
  input  acc_params_t                            acc_params,
  output logic [PE_ROWS-1:0][PE_COLS-1:0]        add_mux_ctrl,
  output logic [PE_ROWS-1:0][ROW_MUX_W-1:0]      row_out_mux_ctrl,
  output logic [PSUM_MUX_W-1:0]                  psum_out_mux_ctrl,
  output logic                                   mac_enable
);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      add_mux_ctrl <= '0;
      row_out_mux_ctrl <= '0;
      psum_out_mux_ctrl <= '0;
      mac_enable <= 1'b0;
    end else if (acc_params.valid) begin
      // active window is the top left filt_r x filt_s corner
      for (int r = 0; r < PE_ROWS; r++) begin
        for (int c = 0; c < PE_COLS; c++) begin
          add_mux_ctrl[r][c] <= (c < int'(acc_params.filt_s)) &&
                                (r < int'(acc_params.filt_r));
        end
      end
      // every row taps the same stage
      for (int r = 0; r < PE_ROWS; r++) begin
        row_out_mux_ctrl[r] <= acc_params.tile_size - 4'd1;
      end
      psum_out_mux_ctrl <= PSUM_MUX_W'(acc_params.filt_r - 4'd1);
      mac_enable <= 1'b1;
    end
  end

  // a filter larger than the array would select rows that do not exist
  a_filt_fits: assert property (@(posedge CLK) disable iff (!rst_n)
    acc_params.valid |-> (int'(acc_params.filt_r) <= PE_ROWS) &&
                         (int'(acc_params.filt_s) <= PE_COLS));

endmodule

//--- logic/buffer_loader.sv
// ~~~~~~~~~~~~~~~~~~~~
// one burst in flight, next one only after txn_done
// full buffers are flagged as errors, never stalled
// ~~~~~~~~~~~~~~~~~~~~
module buffer_loader import pe_ctrl_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  buf_req_t          buf_req,
  input  logic [DATA_W-1:0] weight_base_addr,
  input  logic [DATA_W-1:0] input_base_addr,
  input  logic [DATA_W-1:0] psum_base_addr,
  input  logic [DATA_W-1:0] m_axi_rdata,
  input  logic              rd_beat,
  input  logic              txn_done,
  input  logic              axi_error,
  input  buf_req_t          buf_full,
  output logic              init_rd_txn,
  output logic [DATA_W-1:0] rd_addr,
  output buf_req_t          buf_wr,
  output logic [DATA_W-1:0] buf_wr_data,
  output buf_req_t          buf_done,
  output buf_req_t          buf_err
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_FINISH
  } state_t;

  state_t                 state;
  buf_req_t               pend;
  buf_req_t               pick;
  buf_req_t               act_kind;
  logic [BURST_CNT_W-1:0] burst_cnt;
  logic [BURST_CNT_W-1:0] last_idx;
  logic [DATA_W-1:0]      addr_off;
  logic [DATA_W-1:0]      base_sel;
  logic                   err_acc;
  logic                   beat_err;
  logic                   burst_err;

  // weights first, psums last
  always_comb begin
    pick = '0;
    if (pend.weights) begin
      pick.weights = 1'b1;
    end else if (pend.inputs) begin
      pick.inputs = 1'b1;
    end else if (pend.psums) begin
      pick.psums = 1'b1;
    end
  end

  // base address and burst count of the kind being loaded
  always_comb begin
    base_sel = TARGET_BASE_ADDR;
    last_idx = '0;
    if (act_kind.weights) begin
      base_sel = weight_base_addr;
      last_idx = BURST_CNT_W'(WEIGHT_BURSTS - 1);
    end else if (act_kind.inputs) begin
      base_sel = input_base_addr;
      last_idx = BURST_CNT_W'(INPUT_BURSTS - 1);
    end else if (act_kind.psums) begin
      base_sel = psum_base_addr;
      last_idx = BURST_CNT_W'(PSUM_BURSTS - 1);
    end
  end

  assign beat_err = rd_beat && (|(buf_full & act_kind));
  // includes whatever goes wrong in the closing cycle
  assign burst_err = err_acc || beat_err || (txn_done && axi_error);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      pend <= '0;
      act_kind <= '0;
      burst_cnt <= '0;
      addr_off <= '0;
      err_acc <= 1'b0;
      init_rd_txn <= 1'b0;
      rd_addr <= TARGET_BASE_ADDR;
      buf_wr <= '0;
      buf_done <= '0;
      buf_err <= '0;
    end else begin
      init_rd_txn <= 1'b0;
      buf_wr <= '0;
      buf_done <= '0;
      buf_err <= '0;
      pend <= pend | buf_req;
      case (state)
        ST_IDLE: begin
          if (|pend) begin
            pend <= (pend & ~pick) | buf_req;
            act_kind <= pick;
            burst_cnt <= '0;
            addr_off <= '0;
            err_acc <= 1'b0;
            state <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          init_rd_txn <= 1'b1;
          rd_addr <= base_sel + addr_off;
          addr_off <= addr_off + DATA_W'(BURST_BYTES);
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          if (rd_beat) begin
            buf_wr <= act_kind;
          end
          if (beat_err) begin
            err_acc <= 1'b1;
          end
          if (txn_done) begin
            if (axi_error) begin
              err_acc <= 1'b1;
            end
            if (burst_cnt == last_idx) begin
              buf_done <= act_kind;
              if (burst_err) begin
                buf_err <= act_kind;
              end
              state <= ST_FINISH;
            end else begin
              burst_cnt <= burst_cnt + 1'b1;
              state <= ST_ISSUE;
            end
          end
        end
        ST_FINISH: begin
          act_kind <= '0;
          rd_addr <= TARGET_BASE_ADDR;
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_beat) begin
      buf_wr_data <= m_axi_rdata;
    end
  end

  // each init is followed by at least one idle cycle
  a_init_single: assert property (@(posedge CLK) disable iff (!rst_n)
    init_rd_txn |=> !init_rd_txn);

  // beats go to a single buffer
  a_wr_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
    $onehot0(buf_wr));

endmodule

//--- logic/pe_status.sv
// ~~~~~~~~~~~~~~~~~~~~
// a new request for a kind wins over its done or error pulse
// start clears every error flag
// ~~~~~~~~~~~~~~~~~~~~
module pe_status import pe_ctrl_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       start_pulse,
  input  buf_req_t   buf_req,
  input  buf_req_t   buf_done,
  input  buf_req_t   buf_err,
  output pe_status_t pe_status
);

  // buf_req_t order, weights on top
  logic [2:0] buffered;
  logic [2:0] errored;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      buffered <= '0;
      errored <= '0;
    end else begin
      buffered <= (buffered | buf_done) & ~buf_req;
      errored <= (errored | buf_err) & ~buf_req & ~{3{start_pulse}};
    end
  end

  always_comb begin
    pe_status = '0;
    pe_status.weight_err = errored[2];
    pe_status.input_err = errored[1];
    pe_status.psum_err = errored[0];
    pe_status.weights_buffered = buffered[2];
    pe_status.inputs_buffered = buffered[1];
    pe_status.psums_buffered = buffered[0];
  end

endmodule

//--- logic/pe_control_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// soft_reset acts like resetn_all, at the next clock edge
// buffers and their full flags live outside
// ~~~~~~~~~~~~~~~~~~~~
module pe_control_unit import pe_ctrl_pkg::*; (
  input  logic                              CLK,
  input  logic                              resetn_all,
  input  acc_params_t                       acc_params,
  input  mem_ctrl_t                         mem_ctrl,
  input  logic [DATA_W-1:0]                 weight_base_addr,
  input  logic [DATA_W-1:0]                 input_base_addr,
  input  logic [DATA_W-1:0]                 psum_base_addr,
  input  logic [DATA_W-1:0]                 m_axi_rdata,
  input  logic                              rd_beat,
  input  logic                              txn_done,
  input  logic                              axi_error,
  input  buf_req_t                          buf_full,
  output pe_status_t                        pe_status,
  output logic [PE_ROWS-1:0][PE_COLS-1:0]   add_mux_ctrl,
  output logic [PE_ROWS-1:0][ROW_MUX_W-1:0] row_out_mux_ctrl,
  output logic [PSUM_MUX_W-1:0]             psum_out_mux_ctrl,
  output logic                              mac_enable,
  output logic                              init_rd_txn,
  output logic [DATA_W-1:0]                 rd_addr,
  output buf_req_t                          buf_wr,
  output logic [DATA_W-1:0]                 buf_wr_data
);

  logic     rst_n;
  logic     start_pulse;
  buf_req_t buf_req;
  buf_req_t buf_done;
  buf_req_t buf_err;

  assign rst_n = resetn_all && !acc_params.soft_reset;

  ctrl_edge_detect u_edge (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .acc_params  (acc_params),
    .mem_ctrl    (mem_ctrl),
    .start_pulse (start_pulse),
    .buf_req     (buf_req)
  );

  array_config u_array_cfg (
    .CLK               (CLK),
    .rst_n             (rst_n),
    .acc_params        (acc_params),
    .add_mux_ctrl      (add_mux_ctrl),
    .row_out_mux_ctrl  (row_out_mux_ctrl),
    .psum_out_mux_ctrl (psum_out_mux_ctrl),
    .mac_enable        (mac_enable)
  );

  buffer_loader u_loader (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .buf_req          (buf_req),
    .weight_base_addr (weight_base_addr),
    .input_base_addr  (input_base_addr),
    .psum_base_addr   (psum_base_addr),
    .m_axi_rdata      (m_axi_rdata),
    .rd_beat          (rd_beat),
    .txn_done         (txn_done),
    .axi_error        (axi_error),
    .buf_full         (buf_full),
    .init_rd_txn      (init_rd_txn),
    .rd_addr          (rd_addr),
    .buf_wr           (buf_wr),
    .buf_wr_data      (buf_wr_data),
    .buf_done         (buf_done),
    .buf_err          (buf_err)
  );

  pe_status u_status (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .start_pulse (start_pulse),
    .buf_req     (buf_req),
    .buf_done    (buf_done),
    .buf_err     (buf_err),
    .pe_status   (pe_status)
  );

endmodule

//--- sim/pe_ctrl_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// samples on the rising edge and compares registered outputs one cycle late
// burst order must be announced with expect_bursts
// ~~~~~~~~~~~~~~~~~~~~
module pe_ctrl_checker import pe_ctrl_pkg::*; (
  input  logic                              CLK,
  input  logic                              resetn_all,
  input  acc_params_t                       acc_params,
  input  logic [DATA_W-1:0]                 weight_base_addr,
  input  logic [DATA_W-1:0]                 input_base_addr,
  input  logic [DATA_W-1:0]                 psum_base_addr,
  input  logic [DATA_W-1:0]                 m_axi_rdata,
  input  logic                              rd_beat,
  input  logic                              init_rd_txn,
  input  logic [DATA_W-1:0]                 rd_addr,
  input  buf_req_t                          buf_wr,
  input  logic [DATA_W-1:0]                 buf_wr_data,
  input  logic [PE_ROWS-1:0][PE_COLS-1:0]   add_mux_ctrl,
  input  logic [PE_ROWS-1:0][ROW_MUX_W-1:0] row_out_mux_ctrl,
  input  logic [PSUM_MUX_W-1:0]             psum_out_mux_ctrl,
  input  logic                              mac_enable,
  output int                                errors
);
  timeunit 1ns;
  timeprecision 1ps;

  // error counts for config, burst, beat and status
  int          errs [4] = '{0, 0, 0, 0};
  int          kind_q [$];
  int          idx_q [$];
  int          cur_kind = 0;
  acc_params_t params_q;
  logic        cfg_q = 1'b0;
  logic        beat_q = 1'b0;
  logic [DATA_W-1:0] data_q;

  assign errors = errs[0] + errs[1] + errs[2] + errs[3];

  function automatic logic [PE_ROWS-1:0][PE_COLS-1:0] add_mux_window(acc_params_t p);
    logic [PE_ROWS-1:0][PE_COLS-1:0] m;
    m = '0;
    for (int r = 0; r < PE_ROWS; r++) begin
      for (int c = 0; c < PE_COLS; c++) begin
        m[r][c] = (r < p.filt_r) && (c < p.filt_s);
      end
    end
    return m;
  endfunction

  function automatic logic [PE_ROWS-1:0][ROW_MUX_W-1:0] row_mux_sel(acc_params_t p);
    logic [PE_ROWS-1:0][ROW_MUX_W-1:0] m;
    for (int r = 0; r < PE_ROWS; r++) begin
      m[r] = p.tile_size - 4'd1;
    end
    return m;
  endfunction

  function automatic logic [PSUM_MUX_W-1:0] psum_mux_sel(acc_params_t p);
    logic [3:0] v;
    v = p.filt_r - 4'd1;
    return v[PSUM_MUX_W-1:0];
  endfunction

  // kind 0 is weights, 1 inputs and 2 psums
  function automatic logic [DATA_W-1:0] burst_addr(int kind, int idx);
    logic [DATA_W-1:0] base;
    base = (kind == 0) ? weight_base_addr : (kind == 1) ? input_base_addr : psum_base_addr;
    return base + DATA_W'(idx * 64);
  endfunction

  task automatic compare(int cat, string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      errs[cat]++;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic expect_bursts(int kind, int n);
    for (int i = 0; i < n; i++) begin
      kind_q.push_back(kind);
      idx_q.push_back(i);
    end
  endtask

  task automatic report_counts();
    if (kind_q.size() != 0) begin
      errs[1]++;
      $display("%0d expected bursts were never issued", kind_q.size());
    end
    $display("errors: config %0d, burst %0d, beat %0d, status %0d",
             errs[0], errs[1], errs[2], errs[3]);
  endtask

  always @(posedge CLK) begin
    if (cfg_q) begin
      compare(0, "add_mux_ctrl", 64'(add_mux_window(params_q)), 64'(add_mux_ctrl));
      compare(0, "row_out_mux_ctrl", 64'(row_mux_sel(params_q)), 64'(row_out_mux_ctrl));
      compare(0, "psum_out_mux_ctrl", 64'(psum_mux_sel(params_q)), 64'(psum_out_mux_ctrl));
      compare(0, "mac_enable", 64'(1), 64'(mac_enable));
    end
    if (beat_q) begin
      compare(2, "buf_wr", 64'(3'b100 >> cur_kind), 64'(buf_wr));
      compare(2, "buf_wr_data", 64'(data_q), 64'(buf_wr_data));
    end else begin
      compare(2, "buf_wr idle", 64'(0), 64'(buf_wr));
    end
    if (init_rd_txn) begin
      if (kind_q.size() == 0) begin
        errs[1]++;
        $display("unexpected burst request at address %h", rd_addr);
      end else begin
        cur_kind = kind_q.pop_front();
        compare(1, "rd_addr", 64'(burst_addr(cur_kind, idx_q.pop_front())), 64'(rd_addr));
      end
    end
    cfg_q = resetn_all && !acc_params.soft_reset && acc_params.valid;
    params_q = acc_params;
    beat_q = resetn_all && !acc_params.soft_reset && rd_beat;
    data_q = m_axi_rdata;
  end

endmodule

//--- sim/tb_pe_control_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// inputs change on the falling edge
// the responder models the AXI read side
// ~~~~~~~~~~~~~~~~~~~~
module tb_pe_control_unit import pe_ctrl_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  logic CLK = 1'b0;
  logic resetn_all;
  acc_params_t acc_params;
  mem_ctrl_t mem_ctrl;
  logic [DATA_W-1:0] weight_base_addr, input_base_addr, psum_base_addr, m_axi_rdata;
  logic rd_beat, txn_done, axi_error, mac_enable, init_rd_txn;
  buf_req_t buf_full, buf_wr;
  pe_status_t pe_status, exp_status;
  logic [PE_ROWS-1:0][PE_COLS-1:0] add_mux_ctrl;
  logic [PE_ROWS-1:0][ROW_MUX_W-1:0] row_out_mux_ctrl;
  logic [PSUM_MUX_W-1:0] psum_out_mux_ctrl;
  logic [DATA_W-1:0] rd_addr, buf_wr_data;
  logic timed_out = 1'b0;
  int errors;

  always #20 CLK = ~CLK;

  pe_control_unit UUT (.*);
  pe_ctrl_checker chk (.*);

  task automatic tick();
    @(negedge CLK);
  endtask

  task automatic wait_init();
    int cnt;
    cnt = 0;
    while (!init_rd_txn && !timed_out) begin
      tick();
      cnt++;
      if (cnt > 200) begin
        timed_out = 1'b1;
        $display("timed out waiting for a burst request from the DUT");
      end
    end
  endtask

  // 16 beats with random gaps and err on txn_done
  task automatic serve_burst(logic err);
    wait_init();
    tick();
    repeat ($urandom % 4) tick();
    for (int b = 0; b < BURST_LEN; b++) begin
      repeat ($urandom % 3) begin
        rd_beat = 1'b0;
        tick();
      end
      rd_beat = 1'b1;
      m_axi_rdata = $urandom;
      tick();
    end
    rd_beat = 1'b0;
    txn_done = 1'b1;
    axi_error = err;
    tick();
    txn_done = 1'b0;
    axi_error = 1'b0;
  endtask

  task automatic request(logic w, logic i, logic p);
    mem_ctrl.buffer_weights = w;
    mem_ctrl.buffer_inputs = i;
    mem_ctrl.buffer_psums = p;
    tick();
    mem_ctrl = '0;
  endtask

  initial begin
    void'($urandom(14456));
    {resetn_all, rd_beat, txn_done, axi_error} = '0;
    {acc_params, mem_ctrl, buf_full, m_axi_rdata} = '0;
    weight_base_addr = 32'h1000_0000;
    input_base_addr = 32'h2000_0400;
    psum_base_addr = 32'h3000_0800;
    exp_status = '0;
    repeat (2) tick();
    resetn_all = 1'b1;
    tick();
    // configuration words
    repeat (10) begin
      acc_params = $urandom;
      acc_params.soft_reset = 1'b0;
      acc_params.valid = 1'b1;
      acc_params.filt_r = 4'(1 + $urandom % 5);
      acc_params.filt_s = 4'(1 + $urandom % 5);
      tick();
      acc_params.valid = 1'b0;
      tick();
    end
    // separate requests with an AXI error on inputs and a full psum buffer
    chk.expect_bursts(0, WEIGHT_BURSTS);
    request(1, 0, 0);
    serve_burst(0);
    tick();
    exp_status.weights_buffered = 1'b1;
    chk.compare(3, "status weights", 64'(exp_status), 64'(pe_status));
    chk.expect_bursts(1, INPUT_BURSTS);
    request(0, 1, 0);
    serve_burst(0);
    serve_burst(1);
    tick();
    exp_status.inputs_buffered = 1'b1;
    exp_status.input_err = 1'b1;
    chk.compare(3, "status inputs", 64'(exp_status), 64'(pe_status));
    chk.expect_bursts(2, PSUM_BURSTS);
    request(0, 0, 1);
    buf_full.psums = 1'b1;
    repeat (PSUM_BURSTS) serve_burst(0);
    buf_full = '0;
    tick();
    exp_status.psums_buffered = 1'b1;
    exp_status.psum_err = 1'b1;
    chk.compare(3, "status psums", 64'(exp_status), 64'(pe_status));
    // a new request clears the kind's flags before it loads
    request(0, 1, 0);
    tick();
    exp_status.inputs_buffered = 1'b0;
    exp_status.input_err = 1'b0;
    chk.compare(3, "status input clear", 64'(exp_status), 64'(pe_status));
    chk.expect_bursts(1, INPUT_BURSTS);
    repeat (INPUT_BURSTS) serve_burst(0);
    // all three together must load weights first
    chk.expect_bursts(0, WEIGHT_BURSTS);
    chk.expect_bursts(1, INPUT_BURSTS);
    chk.expect_bursts(2, PSUM_BURSTS);
    request(1, 1, 1);
    repeat (WEIGHT_BURSTS + INPUT_BURSTS + PSUM_BURSTS) serve_burst(0);
    tick();
    exp_status = '0;
    exp_status.weights_buffered = 1'b1;
    exp_status.inputs_buffered = 1'b1;
    exp_status.psums_buffered = 1'b1;
    chk.compare(3, "status all", 64'(exp_status), 64'(pe_status));
    // soft reset lands on the edge that would issue a weight burst
    acc_params.valid = 1'b1;
    acc_params.filt_r = 4'd5;
    acc_params.filt_s = 4'd5;
    acc_params.tile_size = 4'd8;
    request(1, 0, 0);
    acc_params.valid = 1'b0;
    repeat (2) tick();
    acc_params.soft_reset = 1'b1;
    tick();
    chk.compare(3, "soft reset status", 64'(0), 64'(pe_status));
    chk.compare(0, "soft reset mac_enable", 64'(0), 64'(mac_enable));
    chk.compare(0, "soft reset add_mux_ctrl", 64'(0), 64'(add_mux_ctrl));
    chk.compare(0, "soft reset row_out_mux_ctrl", 64'(0), 64'(row_out_mux_ctrl));
    chk.compare(0, "soft reset psum_out_mux_ctrl", 64'(0), 64'(psum_out_mux_ctrl));
    chk.compare(1, "soft reset init_rd_txn", 64'(0), 64'(init_rd_txn));
    chk.compare(1, "soft reset rd_addr", 64'(TARGET_BASE_ADDR), 64'(rd_addr));
    acc_params.soft_reset = 1'b0;
    repeat (2) tick();
    chk.report_counts();
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
logic/pe_ctrl_pkg.sv
logic/ctrl_edge_detect.sv
logic/array_config.sv
logic/buffer_loader.sv
logic/pe_status.sv
logic/pe_control_unit.sv
sim/pe_ctrl_checker.sv
sim/tb_pe_control_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PE control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_pe_control_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_pe_control_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0
